//--- logic/core_io_pkg.sv
package core_io_pkg;

  // Internal I/O register indices, taken from address bits 7 to 2
  typedef enum logic [5:0] {
    // Write side
    io_send_desc_l  = 6'h02,
    io_send_desc_h  = 6'h03,
    io_dram_addr_l  = 6'h04,
    io_dram_addr_h  = 6'h05,
    io_slot_data    = 6'h06,
    io_timer_step   = 6'h07,
    io_flag_wr      = 6'h08,
    io_evict_rdy    = 6'h09,
    io_desc_type    = 6'h0a,
    io_desc_take    = 6'h0b,
    io_flag_rst     = 6'h0c,
    io_slot_strb    = 6'h0d,
    io_mask_wr      = 6'h0e,
    io_irq_ack      = 6'h0f,
    io_debug_l      = 6'h10,
    io_debug_h      = 6'h11,
    // Read side
    io_rd_desc_l    = 6'h20,
    io_rd_desc_h    = 6'h21,
    io_rd_flags     = 6'h22,
    io_rd_status    = 6'h23,
    io_rd_id        = 6'h24,
    io_rd_timer_l   = 6'h25,
    io_rd_timer_h   = 6'h26,
    io_rd_irq       = 6'h27,
    io_rd_slots     = 6'h28,
    io_rd_imem_size = 6'h29,
    io_rd_dmem_size = 6'h2a,
    io_rd_pmem_size = 6'h2b,
    io_rd_seg_size  = 6'h2c,
    io_rd_seg_count = 6'h2d,
    io_rd_bc_size   = 6'h2e,
    io_rd_max_slots = 6'h2f,
    io_rd_debug_l   = 6'h30,
    io_rd_debug_h   = 6'h31
  } io_addr_e;

  // Control view of a write word; bit 0 is both strobe and timer ack
  typedef struct packed {
    logic [23:0] rsvd;
    logic [3:0]  err_clr;     // io, pmem, dmem, imem
    logic        ext_ack;
    logic        evict_ack;
    logic        poke_ack;
    logic        strobe;
  } wr_ctrl_t;

  typedef union packed {
    logic [3:0][7:0] lane;
    wr_ctrl_t        ctrl;
  } wdata_u;

  // Raw interrupt sources, in mask bit order
  typedef struct packed {
    logic ext_err;
    logic evict;
    logic poke;
    logic timer;
    logic dram_any;
    logic in_desc;
  } irq_lines_t;

endpackage

//--- logic/core_bus_pkg.sv
package core_bus_pkg;

  import core_io_pkg::*;

  // Access size as driven by the core
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_e;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    size_e       size;
  } dbus_cmd_t;

  typedef struct packed {
    logic dmem;
    logic pmem;
    logic exio;
    logic intio;
  } region_t;

  // One decoded internal I/O access
  typedef struct packed {
    logic       read;
    logic       write;
    logic [5:0] idx;
    logic [3:0] strb;
    wdata_u     wdata;
  } io_acc_t;

  // Fetch and data access, one cycle late, for range checks
  typedef struct packed {
    logic        imem_ren;
    logic [31:0] imem_addr;
    region_t     region;
    logic [31:0] daddr;
  } access_reg_t;

endpackage

//--- logic/bus_decode.sv
`timescale 1ns/1ps

module bus_decode import core_bus_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  dbus_cmd_t   cmd,
  input  logic        imem_ren,
  input  logic [24:0] imem_addr,
  output region_t     region,
  output logic [3:0]  mem_strb,
  output logic [24:0] mem_addr,
  output io_acc_t     io,
  output access_reg_t acc
);

  logic [3:0] size_mask;

  // Region map on address bits 24 to 22
  assign region.intio = cmd.valid && (cmd.addr[24:22] == 3'b000);
  assign region.exio  = cmd.valid && (cmd.addr[24:22] == 3'b001);
  assign region.dmem  = cmd.valid && (cmd.addr[24:23] == 2'b01);
  assign region.pmem  = cmd.valid && cmd.addr[24];

  always_comb begin
    case (cmd.size)
      size_byte: size_mask = 4'b0001;
      size_half: size_mask = 4'b0011;
      default:   size_mask = 4'b1111;
    endcase
  end

  // Reads carry no strobes
  assign mem_strb = (cmd.valid && cmd.write) ? 4'(size_mask << cmd.addr[1:0]) : 4'd0;
  assign mem_addr = cmd.addr[24:0];

  assign io.read  = region.intio && !cmd.write;
  assign io.write = region.intio && cmd.write;
  assign io.idx   = cmd.addr[7:2];
  assign io.strb  = mem_strb;
  assign io.wdata = cmd.wdata;

  always_ff @(posedge clk) begin
    acc.imem_ren  <= imem_ren;
    acc.imem_addr <= {7'd0, imem_addr};
    acc.region    <= region;
    acc.daddr     <= cmd.addr;
    if (rst) begin
      acc.imem_ren <= 1'b0;
      acc.region   <= '0;
    end
  end

endmodule

//--- logic/io_write_regs.sv
`timescale 1ns/1ps

module io_write_regs import core_bus_pkg::*, core_io_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  io_acc_t     io,
  input  logic        out_desc_ready,
  output logic [63:0] out_desc,
  output logic        out_desc_valid,
  output logic [63:0] out_desc_dram_addr,
  output logic        in_desc_taken,
  output logic [31:0] slot_wr_data,
  output logic        slot_wr_valid,
  output logic [63:0] debug_out,
  output logic        debug_out_l_valid,
  output logic        debug_out_h_valid,
  output logic        ready_to_evict,
  output logic [7:0]  mask,
  output logic [31:0] step,
  output logic        step_wr,
  output logic [3:0]  irq_ack,
  output logic [3:0]  err_clr
);

  logic [63:0] desc_data;
  logic [3:0]  desc_type;
  logic        ack_wr;

  //////////////////////////////////////////////////////////////////////
  // Byte-strobed registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (io.write) begin
      for (int i = 0; i < 4; i++) begin
        if (io.strb[i]) begin
          case (io.idx)
            io_send_desc_l: desc_data[i*8 +: 8]             <= io.wdata.lane[i];
            io_send_desc_h: desc_data[32+i*8 +: 8]          <= io.wdata.lane[i];
            io_dram_addr_l: out_desc_dram_addr[i*8 +: 8]    <= io.wdata.lane[i];
            io_dram_addr_h: out_desc_dram_addr[32+i*8 +: 8] <= io.wdata.lane[i];
            io_slot_data:   slot_wr_data[i*8 +: 8]          <= io.wdata.lane[i];
            io_timer_step:  step[i*8 +: 8]                  <= io.wdata.lane[i];
            io_debug_l:     debug_out[i*8 +: 8]             <= io.wdata.lane[i];
            io_debug_h:     debug_out[32+i*8 +: 8]          <= io.wdata.lane[i];
            default: ;
          endcase
        end
      end
      // Type write also launches the descriptor
      if (io.idx == io_desc_type)
        desc_type <= io.wdata.lane[0][3:0];
      if (io.idx == io_mask_wr)
        mask <= io.wdata.lane[0];
      if (io.idx == io_evict_rdy)
        ready_to_evict <= io.wdata.ctrl.strobe;
    end
    if (rst) begin
      step           <= 32'd1;
      mask           <= 8'hc0;
      ready_to_evict <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Descriptor handshake and debug valids
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_desc_valid    <= 1'b0;
      debug_out_l_valid <= 1'b0;
      debug_out_h_valid <= 1'b0;
    end else begin
      debug_out_l_valid <= io.write && (io.idx == io_debug_l);
      debug_out_h_valid <= io.write && (io.idx == io_debug_h);
      if (io.write && (io.idx == io_desc_type))
        out_desc_valid <= 1'b1;
      // Accept by the consumer wins
      if (out_desc_valid && out_desc_ready)
        out_desc_valid <= 1'b0;
    end
  end

  assign out_desc      = {desc_type, desc_data[59:0]};
  assign in_desc_taken = io.write && (io.idx == io_desc_take) && io.wdata.ctrl.strobe;
  assign slot_wr_valid = io.write && (io.idx == io_slot_strb) && io.wdata.ctrl.strobe;
  assign step_wr       = io.write && (io.idx == io_timer_step);

  // Acks and error clears share one register
  assign ack_wr  = io.write && (io.idx == io_irq_ack);
  assign irq_ack = ack_wr ? {io.wdata.ctrl.ext_ack, io.wdata.ctrl.evict_ack,
                             io.wdata.ctrl.poke_ack, io.wdata.ctrl.strobe} : 4'd0;
  assign err_clr = ack_wr ? io.wdata.ctrl.err_clr : 4'd0;

endmodule

//--- logic/event_timer.sv
`timescale 1ns/1ps

module event_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        init_rst,
  input  logic [31:0] step,
  input  logic        step_wr,
  input  logic        timer_ack,
  output logic [63:0] timer,
  output logic        timer_irq
);

  logic [31:0] interval;

  // Free running, survives core reset
  always_ff @(posedge clk) begin
    if (init_rst)
      timer <= 64'd0;
    else
      timer <= timer + 64'd1;
  end

  // A new step restarts the interval
  always_ff @(posedge clk) begin
    if (rst || step_wr) begin
      interval  <= 32'd0;
      timer_irq <= 1'b0;
    end else if (interval == step) begin
      interval  <= 32'd0;
      timer_irq <= 1'b1;
    end else begin
      interval <= interval + 32'd1;
      if (timer_ack)
        timer_irq <= 1'b0;
    end
  end

endmodule

//--- logic/dram_recv_flags.sv
`timescale 1ns/1ps

module dram_recv_flags import core_bus_pkg::*, core_io_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  io_acc_t     io,
  input  logic [4:0]  recv_dram_tag,
  input  logic        recv_dram_tag_valid,
  output logic [31:0] flags
);

  logic [4:0] tag_q;
  logic       tag_valid_q;

  // Tag input retimed before use
  always_ff @(posedge clk) begin
    tag_q       <= recv_dram_tag;
    tag_valid_q <= recv_dram_tag_valid;
    if (rst)
      tag_valid_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= 32'd0;
    end else begin
      if (io.write && (io.idx == io_flag_wr)) begin
        for (int i = 0; i < 4; i++) begin
          if (io.strb[i])
            flags[i*8 +: 8] <= io.wdata.lane[i];
        end
      end
      if (io.write && (io.idx == io_flag_rst))
        flags[io.wdata.lane[0][4:0]] <= 1'b0;
      // Arriving tag beats a clear of the same bit
      if (tag_valid_q)
        flags[tag_q] <= 1'b1;
      flags[0] <= 1'b0;
    end
  end

endmodule

//--- logic/access_error_check.sv
`timescale 1ns/1ps

module access_error_check import core_bus_pkg::*; #(
  parameter int unsigned imem_size = 65536,
  parameter int unsigned dmem_size = 32768,
  parameter int unsigned pmem_size = 1048576
) (
  input  logic        clk,
  input  logic        rst,
  input  access_reg_t acc,
  input  logic [3:0]  err_clr,
  output logic [3:0]  errors
);

  logic [3:0] out_of_range;

  // Bit order is imem, dmem, pmem, io
  assign out_of_range[0] = acc.imem_ren && (acc.imem_addr >= imem_size);
  assign out_of_range[1] = acc.region.dmem && (acc.daddr[22:0] >= dmem_size);
  assign out_of_range[2] = acc.region.pmem && (acc.daddr[23:0] >= pmem_size);
  // Internal I/O only decodes the first 256 bytes
  assign out_of_range[3] = acc.region.intio && (acc.daddr[21:0] >= 22'h000100);

  // Sticky until cleared by an ack write
  always_ff @(posedge clk) begin
    if (rst)
      errors <= 4'd0;
    else
      errors <= ~err_clr & (errors | out_of_range);
  end

endmodule

//--- logic/io_read_mux.sv
`timescale 1ns/1ps

module io_read_mux import core_bus_pkg::*, core_io_pkg::*; #(
  parameter int unsigned imem_size      = 65536,
  parameter int unsigned dmem_size      = 32768,
  parameter int unsigned pmem_size      = 1048576,
  parameter int unsigned pmem_seg_size  = 131072,
  parameter int unsigned pmem_seg_count = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  io_acc_t     io,
  input  irq_lines_t  irq,
  input  logic [7:0]  mask,
  input  logic [3:0]  errors,
  input  logic [31:0] flags,
  input  logic [63:0] timer,
  input  logic [63:0] in_desc,
  input  logic        in_desc_valid,
  input  logic        out_desc_ready,
  input  logic        slot_wr_ready,
  input  logic        core_msg_ready,
  input  logic [7:0]  core_id,
  input  logic [31:0] active_slots,
  input  logic [15:0] bc_region_size,
  input  logic [7:0]  max_slot_count,
  input  logic [63:0] debug_in,
  input  logic [31:0] mem_rd_data,
  input  logic        mem_rd_valid,
  output logic        rsp_ready,
  output logic [31:0] rsp_data,
  output logic        rsp_error,
  output logic        timer_irq_out,
  output logic        ext_irq
);

  logic [31:0] rd_word;
  logic        rd_valid;

  always_ff @(posedge clk) begin
    if (rst)
      rd_valid <= 1'b0;
    else
      rd_valid <= io.read;
  end

  //////////////////////////////////////////////////////////////////////
  // Read map, held when nothing matches
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (io.read) begin
      case (io.idx)
        io_rd_desc_l:    if (in_desc_valid) rd_word <= in_desc[31:0];
        io_rd_desc_h:    if (in_desc_valid) rd_word <= in_desc[63:32];
        io_rd_flags:     rd_word <= flags;
        io_rd_status:    rd_word <= {7'd0, core_msg_ready, 7'd0, slot_wr_ready,
                                     7'd0, out_desc_ready, 7'd0, in_desc_valid};
        io_rd_id:        rd_word <= {24'd0, core_id};
        io_rd_timer_l:   rd_word <= timer[31:0];
        io_rd_timer_h:   rd_word <= timer[63:32];
        io_rd_irq:       rd_word <= {10'd0, irq, mask, 4'd0, errors};
        io_rd_slots:     rd_word <= active_slots;
        io_rd_imem_size: rd_word <= 32'(imem_size);
        io_rd_dmem_size: rd_word <= 32'(dmem_size);
        io_rd_pmem_size: rd_word <= 32'(pmem_size);
        io_rd_seg_size:  rd_word <= 32'(pmem_seg_size);
        io_rd_seg_count: rd_word <= 32'(pmem_seg_count);
        io_rd_bc_size:   rd_word <= {16'd0, bc_region_size};
        io_rd_max_slots: rd_word <= {24'd0, max_slot_count};
        io_rd_debug_l:   rd_word <= debug_in[31:0];
        io_rd_debug_h:   rd_word <= debug_in[63:32];
        default: ;
      endcase
    end
  end

  // Response back to the core
  assign rsp_ready = mem_rd_valid || rd_valid;
  assign rsp_data  = rd_valid ? rd_word : mem_rd_data;
  assign rsp_error = (|errors[3:1]) && mask[7];

  // Timer goes on its own line, the rest share the external one
  assign timer_irq_out = irq.timer && mask[2];
  assign ext_irq       = |(irq & mask[5:0] & 6'b111011);

endmodule

//--- logic/core_io_top.sv
`timescale 1ns/1ps

module core_io_top import core_bus_pkg::*, core_io_pkg::*; #(
  parameter int unsigned imem_size      = 65536,
  parameter int unsigned dmem_size      = 32768,
  parameter int unsigned pmem_size      = 1048576,
  parameter int unsigned pmem_seg_size  = 131072,
  parameter int unsigned pmem_seg_count = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        init_rst,
  input  dbus_cmd_t   cmd,
  input  logic        imem_ren,
  input  logic [24:0] imem_addr,
  // Memory side
  output logic        dmem_en,
  output logic        pmem_en,
  output logic        exio_en,
  output logic [3:0]  mem_strb,
  output logic [24:0] mem_addr,
  input  logic [31:0] mem_rd_data,
  input  logic        mem_rd_valid,
  // Descriptors
  input  logic [63:0] in_desc,
  input  logic        in_desc_valid,
  output logic        in_desc_taken,
  output logic [63:0] out_desc,
  output logic        out_desc_valid,
  output logic [63:0] out_desc_dram_addr,
  input  logic        out_desc_ready,
  // Slot side status, slot writes and debug
  input  logic [31:0] active_slots,
  input  logic [15:0] bc_region_size,
  input  logic [7:0]  core_id,
  input  logic [7:0]  max_slot_count,
  input  logic [63:0] debug_in,
  input  logic        core_msg_ready,
  output logic [31:0] slot_wr_data,
  output logic        slot_wr_valid,
  input  logic        slot_wr_ready,
  output logic [63:0] debug_out,
  output logic        debug_out_l_valid,
  output logic        debug_out_h_valid,
  output logic        ready_to_evict,
  input  logic [4:0]  recv_dram_tag,
  input  logic        recv_dram_tag_valid,
  // Interrupt sources and their acks
  input  logic        ext_io_err,
  output logic        ext_io_err_ack,
  input  logic        poke_int,
  output logic        poke_int_ack,
  input  logic        evict_int,
  output logic        evict_int_ack,
  output logic [7:0]  core_errors,
  // Core response
  output logic        rsp_ready,
  output logic [31:0] rsp_data,
  output logic        rsp_error,
  output logic        timer_irq,
  output logic        ext_irq
);

  region_t     region;
  io_acc_t     io;
  access_reg_t acc;
  irq_lines_t  irq;
  logic [7:0]  mask;
  logic [31:0] step;
  logic        step_wr;
  logic [3:0]  irq_ack;
  logic [3:0]  err_clr;
  logic [3:0]  errors;
  logic [31:0] flags;
  logic [63:0] timer;
  logic        raw_timer_irq;

  assign dmem_en = region.dmem;
  assign pmem_en = region.pmem;
  assign exio_en = region.exio;

  assign poke_int_ack   = irq_ack[1];
  assign evict_int_ack  = irq_ack[2];
  assign ext_io_err_ack = irq_ack[3];
  assign core_errors    = {3'd0, ext_io_err, errors};

  assign irq.ext_err  = ext_io_err;
  assign irq.evict    = evict_int;
  assign irq.poke     = poke_int;
  assign irq.timer    = raw_timer_irq;
  assign irq.dram_any = |flags;
  assign irq.in_desc  = in_desc_valid;

  bus_decode bus_decode_i (
    .clk, .rst, .cmd, .imem_ren, .imem_addr,
    .region, .mem_strb, .mem_addr, .io, .acc
  );

  io_write_regs io_write_regs_i (
    .clk, .rst, .io, .out_desc_ready, .out_desc, .out_desc_valid, .out_desc_dram_addr,
    .in_desc_taken, .slot_wr_data, .slot_wr_valid, .debug_out, .debug_out_l_valid,
    .debug_out_h_valid, .ready_to_evict, .mask, .step, .step_wr, .irq_ack, .err_clr
  );

  event_timer event_timer_i (
    .clk, .rst, .init_rst, .step, .step_wr,
    .timer_ack (irq_ack[0]),
    .timer,
    .timer_irq (raw_timer_irq)
  );

  dram_recv_flags dram_recv_flags_i (
    .clk, .rst, .io, .recv_dram_tag, .recv_dram_tag_valid, .flags
  );

  access_error_check #(
    .imem_size (imem_size),
    .dmem_size (dmem_size),
    .pmem_size (pmem_size)
  ) access_error_check_i (
    .clk, .rst, .acc, .err_clr, .errors
  );

  io_read_mux #(
    .imem_size      (imem_size),
    .dmem_size      (dmem_size),
    .pmem_size      (pmem_size),
    .pmem_seg_size  (pmem_seg_size),
    .pmem_seg_count (pmem_seg_count)
  ) io_read_mux_i (
    .clk, .rst, .io, .irq, .mask, .errors, .flags, .timer, .in_desc, .in_desc_valid,
    .out_desc_ready, .slot_wr_ready, .core_msg_ready, .core_id, .active_slots,
    .bc_region_size, .max_slot_count, .debug_in, .mem_rd_data, .mem_rd_valid,
    .rsp_ready, .rsp_data, .rsp_error,
    .timer_irq_out (timer_irq),
    .ext_irq
  );

endmodule

//--- bench/core_io_tb.sv
`timescale 1ns/1ps

module core_io_tb import core_bus_pkg::*, core_io_pkg::*;;

  // Run length is about 350 cycles, the limit leaves a wide margin
  localparam int timeout_cycles = 4000;

  typedef struct packed {
    logic [31:0] addr;
    logic [1:0]  size;
    logic        write;
    logic [31:0] data;
    logic [31:0] exp;
    logic        is_read;
  } row_t;

  logic clk, rst, init_rst;
  dbus_cmd_t cmd;
  logic imem_ren;
  logic [24:0] imem_addr;
  logic dmem_en, pmem_en, exio_en;
  logic [3:0] mem_strb;
  logic [24:0] mem_addr;
  logic [31:0] mem_rd_data;
  logic mem_rd_valid;
  logic [63:0] in_desc, out_desc, out_desc_dram_addr, debug_in, debug_out;
  logic in_desc_valid, in_desc_taken, out_desc_valid, out_desc_ready;
  logic [31:0] active_slots, slot_wr_data;
  logic [15:0] bc_region_size;
  logic [7:0] core_id, max_slot_count, core_errors;
  logic core_msg_ready, slot_wr_valid, slot_wr_ready;
  logic debug_out_l_valid, debug_out_h_valid, ready_to_evict;
  logic [4:0] recv_dram_tag;
  logic recv_dram_tag_valid;
  logic ext_io_err, ext_io_err_ack, poke_int, poke_int_ack, evict_int, evict_int_ack;
  logic rsp_ready, rsp_error, timer_irq, ext_irq;
  logic [31:0] rsp_data;

  int err_count = 0;
  int cycles = 0;
  logic [31:0] rnd = 32'hca60_eb40;
  row_t table_rows[$];

  core_io_top core_io_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("Timeout: run did not end within %0d cycles", timeout_cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // Command is driven 1 ns after the edge, sampled 1 ns later
  task automatic issue(input logic [31:0] addr, input logic [1:0] size,
                       input logic write, input logic [31:0] data);
    @(posedge clk);
    #1;
    cmd.valid = 1'b1;
    cmd.write = write;
    cmd.addr  = addr;
    cmd.wdata = data;
    cmd.size  = size_e'(size);
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    cmd.valid = 1'b0;
    cmd.write = 1'b0;
  endtask

  task automatic wr(input logic [31:0] addr, input logic [31:0] data);
    issue(addr, 2'd2, 1'b1, data);
  endtask

  // Read with the response expected exactly one cycle later
  task automatic rd_check(input string what, input logic [31:0] addr, input logic [31:0] exp);
    issue(addr, 2'd2, 1'b0, 32'd0);
    #1;
    check({what, " early rsp_ready"}, rsp_ready, 1'b0);
    idle();
    #1;
    check({what, " rsp_ready"}, rsp_ready, 1'b1);
    check(what, rsp_data, exp);
  endtask

  task automatic add_row(input logic [31:0] addr, input logic [1:0] size, input logic write,
                         input logic [31:0] data, input logic [31:0] exp, input logic is_read);
    table_rows.push_back({addr, size, write, data, exp, is_read});
  endtask

  task automatic report(input int num, input string name, input int errs_before);
    $display("test %0d %s: %s", num, name, (err_count == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    int e0;
    int n;
    logic [31:0] d_lo, d_hi, r;
    logic exp_valid, rdy;

    cmd = '0;
    rst = 1'b1;
    init_rst = 1'b1;
    imem_ren = 1'b0;
    imem_addr = '0;
    mem_rd_data = 32'h0;
    mem_rd_valid = 1'b0;
    in_desc = 64'hfeed_0000_cafe_0001;
    in_desc_valid = 1'b1;
    out_desc_ready = 1'b0;
    active_slots = 32'h0000_00ff;
    bc_region_size = 16'h1234;
    core_id = 8'h5a;
    max_slot_count = 8'd16;
    debug_in = 64'h0123_4567_89ab_cdef;
    core_msg_ready = 1'b0;
    slot_wr_ready = 1'b1;
    recv_dram_tag = '0;
    recv_dram_tag_valid = 1'b0;
    ext_io_err = 1'b0;
    poke_int = 1'b0;
    evict_int = 1'b0;

    // Decode rows: exp holds {dmem, pmem, exio} over the strobes
    add_row(32'h0080_0000, 2'd2, 1'b1, 32'h1111_1111, {25'd0, 3'b100, 4'b1111}, 1'b0);
    add_row(32'h00c0_0003, 2'd0, 1'b1, 32'h2222_2222, {25'd0, 3'b100, 4'b1000}, 1'b0);
    add_row(32'h0100_0002, 2'd1, 1'b1, 32'h3333_3333, {25'd0, 3'b010, 4'b1100}, 1'b0);
    add_row(32'h0040_0001, 2'd0, 1'b1, 32'h4444_4444, {25'd0, 3'b001, 4'b0010}, 1'b0);
    add_row(32'h0140_0000, 2'd2, 1'b0, 32'h0,         {25'd0, 3'b010, 4'b0000}, 1'b0);
    add_row(32'h0000_0004, 2'd1, 1'b1, 32'h5555_5555, {25'd0, 3'b000, 4'b0011}, 1'b0);
    // Read rows: exp is rsp_data
    add_row(32'h0000_0090, 2'd2, 1'b0, 32'h0, 32'h0000_005a, 1'b1);
    add_row(32'h0000_00a0, 2'd2, 1'b0, 32'h0, 32'h0000_00ff, 1'b1);
    add_row(32'h0000_00a4, 2'd2, 1'b0, 32'h0, 32'h0001_0000, 1'b1);
    add_row(32'h0000_00a8, 2'd2, 1'b0, 32'h0, 32'h0000_8000, 1'b1);
    add_row(32'h0000_00ac, 2'd2, 1'b0, 32'h0, 32'h0010_0000, 1'b1);
    add_row(32'h0000_00b0, 2'd2, 1'b0, 32'h0, 32'h0002_0000, 1'b1);
    add_row(32'h0000_00b4, 2'd2, 1'b0, 32'h0, 32'h0000_0008, 1'b1);
    add_row(32'h0000_00b8, 2'd2, 1'b0, 32'h0, 32'h0000_1234, 1'b1);
    add_row(32'h0000_00bc, 2'd2, 1'b0, 32'h0, 32'h0000_0010, 1'b1);
    add_row(32'h0000_008c, 2'd2, 1'b0, 32'h0, 32'h0001_0001, 1'b1);
    add_row(32'h0000_00c0, 2'd2, 1'b0, 32'h0, 32'h89ab_cdef, 1'b1);
    add_row(32'h0000_00c4, 2'd2, 1'b0, 32'h0, 32'h0123_4567, 1'b1);
    add_row(32'h0000_0080, 2'd2, 1'b0, 32'h0, 32'hcafe_0001, 1'b1);
    add_row(32'h0000_0084, 2'd2, 1'b0, 32'h0, 32'hfeed_0000, 1'b1);

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    init_rst = 1'b0;

    ////////////////////////////////////////////////////////////////////
    // Table: region decode, strobes and I/O reads
    ////////////////////////////////////////////////////////////////////
    e0 = err_count;
    foreach (table_rows[i]) begin
      if (!table_rows[i].is_read) begin
        issue(table_rows[i].addr, table_rows[i].size, table_rows[i].write, table_rows[i].data);
        #1;
        check("region and strobes", {dmem_en, pmem_en, exio_en, mem_strb},
              table_rows[i].exp[6:0]);
        check("mem_addr", mem_addr, table_rows[i].addr[24:0]);
        idle();
      end
    end
    report(1, "decode", e0);
    e0 = err_count;
    foreach (table_rows[i]) begin
      if (table_rows[i].is_read)
        rd_check("read data", table_rows[i].addr, table_rows[i].exp);
    end
    // A memory read answers on mem_rd_valid
    rnd = xorshift(rnd);
    @(posedge clk);
    #1;
    mem_rd_data = rnd;
    mem_rd_valid = 1'b1;
    #1;
    check("memory rsp_ready", rsp_ready, 1'b1);
    check("memory rsp_data", rsp_data, rnd);
    @(posedge clk);
    #1;
    mem_rd_valid = 1'b0;
    report(2, "io reads", e0);

    ////////////////////////////////////////////////////////////////////
    // Descriptor, debug, take and slot strobes
    ////////////////////////////////////////////////////////////////////
    e0 = err_count;
    rnd = xorshift(rnd);
    d_lo = rnd;
    rnd = xorshift(rnd);
    d_hi = rnd;
    wr(32'h08, d_lo);
    wr(32'h0c, d_hi);
    wr(32'h10, d_hi);
    wr(32'h14, d_lo);
    wr(32'h28, 32'h0000_000a);
    idle();
    #1;
    check("out_desc_valid", out_desc_valid, 1'b1);
    check("out_desc", out_desc, {4'ha, d_hi[27:0], d_lo});
    check("out_desc_dram_addr", out_desc_dram_addr, {d_lo, d_hi});
    exp_valid = 1'b1;
    rdy = 1'b0;
    for (n = 0; n < 40 && exp_valid; n++) begin
      @(posedge clk);
      #1;
      if (rdy)
        exp_valid = 1'b0;
      rnd = xorshift(rnd);
      rdy = rnd[7];
      out_desc_ready = rdy;
      #1;
      check("out_desc_valid hold", out_desc_valid, exp_valid);
    end
    if (exp_valid) begin
      $display("descriptor was never accepted by the consumer");
      err_count++;
    end
    out_desc_ready = 1'b0;
    rnd = xorshift(rnd);
    r = rnd;
    wr(32'h44, r);
    #1;
    check("debug_out_h_valid early", debug_out_h_valid, 1'b0);
    idle();
    #1;
    check("debug_out_h_valid", debug_out_h_valid, 1'b1);
    check("debug_out high", debug_out[63:32], r);
    wr(32'h40, d_lo);
    issue(32'h42, 2'd1, 1'b1, 32'hbeef_0000);
    idle();
    #1;
    check("debug_out low", debug_out[31:0], {16'hbeef, d_lo[15:0]});
    check("debug_out_l_valid", debug_out_l_valid, 1'b1);
    wr(32'h2c, 32'h1);
    #1;
    check("in_desc_taken set", in_desc_taken, 1'b1);
    wr(32'h2c, 32'h2);
    #1;
    check("in_desc_taken clear", in_desc_taken, 1'b0);
    wr(32'h18, d_hi);
    wr(32'h34, 32'h1);
    #1;
    check("slot_wr_valid set", slot_wr_valid, 1'b1);
    check("slot_wr_data", slot_wr_data, d_hi);
    wr(32'h34, 32'h2);
    #1;
    check("slot_wr_valid clear", slot_wr_valid, 1'b0);
    wr(32'h24, 32'h1);
    idle();
    #1;
    check("ready_to_evict", ready_to_evict, 1'b1);
    report(3, "descriptor and debug", e0);

    ////////////////////////////////////////////////////////////////////
    // DRAM receive flags
    ////////////////////////////////////////////////////////////////////
    e0 = err_count;
    @(posedge clk);
    #1;
    recv_dram_tag = 5'd5;
    recv_dram_tag_valid = 1'b1;
    idle();
    recv_dram_tag_valid = 1'b0;
    rd_check("flag tag 5", 32'h88, 32'h0000_0020);
    @(posedge clk);
    #1;
    recv_dram_tag = 5'd0;
    recv_dram_tag_valid = 1'b1;
    idle();
    recv_dram_tag_valid = 1'b0;
    rd_check("flag tag 0", 32'h88, 32'h0000_0020);
    @(posedge clk);
    #1;
    recv_dram_tag = 5'd9;
    recv_dram_tag_valid = 1'b1;
    // The clear of bit 9 meets the arriving tag
    wr(32'h30, 32'd9);
    recv_dram_tag_valid = 1'b0;
    wr(32'h30, 32'd5);
    idle();
    rd_check("flag reset", 32'h88, 32'h0000_0200);
    report(4, "dram flags", e0);

    ////////////////////////////////////////////////////////////////////
    // Range errors
    ////////////////////////////////////////////////////////////////////
    e0 = err_count;
    // Decode rows 2 and 5 fall beyond the data and packet memories
    check("decode range errors", core_errors[3:0], 4'b0110);
    wr(32'h3c, 32'hf0);
    issue(32'h0080_9000, 2'd2, 1'b0, 32'h0);
    idle();
    #1;
    check("dmem error early", core_errors[1], 1'b0);
    idle();
    #1;
    check("dmem error", core_errors[1], 1'b1);
    check("rsp_error dmem", rsp_error, 1'b1);
    wr(32'h3c, 32'h20);
    idle();
    #1;
    check("dmem error clear", core_errors[1], 1'b0);
    issue(32'h0000_0200, 2'd2, 1'b0, 32'h0);
    idle();
    idle();
    #1;
    check("io error", core_errors[3], 1'b1);
    check("rsp_error io", rsp_error, 1'b1);
    wr(32'h3c, 32'h80);
    idle();
    #1;
    check("io error clear", core_errors[3], 1'b0);
    check("rsp_error clear", rsp_error, 1'b0);
    report(5, "access errors", e0);

    ////////////////////////////////////////////////////////////////////
    // Timer interrupt
    ////////////////////////////////////////////////////////////////////
    e0 = err_count;
    wr(32'h38, 32'hc4);
    wr(32'h1c, 32'd5);
    for (n = 1; n < 200; n++) begin
      idle();
      #1;
      if (timer_irq)
        break;
    end
    // n-1 edges have passed since the step write edge
    check("timer_irq delay", n - 1, 6);
    wr(32'h3c, 32'h1);
    idle();
    #1;
    check("timer_irq ack", timer_irq, 1'b0);
    wr(32'h38, 32'hc0);
    repeat (14) begin
      idle();
      #1;
      check("timer_irq masked", timer_irq, 1'b0);
    end
    // Poke reaches the external line only once its mask bit is set
    wr(32'h38, 32'hc8);
    poke_int = 1'b1;
    #1;
    check("ext_irq masked", ext_irq, 1'b0);
    idle();
    #1;
    check("ext_irq poke", ext_irq, 1'b1);
    wr(32'h3c, 32'h0e);
    #1;
    check("interrupt acks", {ext_io_err_ack, evict_int_ack, poke_int_ack}, 3'b111);
    idle();
    poke_int = 1'b0;
    report(6, "timer", e0);

    $display("tests 6, failures %0d", err_count);
    if (err_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- core_io.f
logic/core_io_pkg.sv
logic/core_bus_pkg.sv
logic/bus_decode.sv
logic/io_write_regs.sv
logic/event_timer.sv
logic/dram_recv_flags.sv
logic/access_error_check.sv
logic/io_read_mux.sv
logic/core_io_top.sv
bench/core_io_tb.sv

//--- Bender.yml
package:
  name: core_io

sources:
  - logic/core_io_pkg.sv
  - logic/core_bus_pkg.sv
  - logic/bus_decode.sv
  - logic/io_write_regs.sv
  - logic/event_timer.sv
  - logic/dram_recv_flags.sv
  - logic/access_error_check.sv
  - logic/io_read_mux.sv
  - logic/core_io_top.sv
  - target: test
    files:
      - bench/core_io_tb.sv
